// ==== include/md_core_consts.svh ====
/*
 * Shared constants for the console core top level.
 * Header addresses are byte addresses into the cartridge ROM image.
 * Widths here size the packed types of md_core_pkg.
 */
`ifndef MD_CORE_CONSTS_SVH
`define MD_CORE_CONSTS_SVH

////////////////////////////////////////
// widths

`define MD_ROM_ADDR_W 25
`define MD_ROM_DATA_W 16
`define MD_HOST_KEY_W 16
`define MD_PAD_W 12
`define MD_COLOR_W 4

////////////////////////////////////////
// cartridge header map

// product ID spans five words, lookup fires on the word after
`define MD_HDR_ID_FIRST 25'h182
`define MD_HDR_ID_LAST 25'h18A
`define MD_HDR_ID_COMMIT 25'h18C

// region letters or hex code
`define MD_HDR_REGION_A 25'h1F0
`define MD_HDR_REGION_B 25'h1F2

`define MD_HDR_END 25'h200 // header fully written

////////////////////////////////////////
// table defaults

`define MD_GUN_DELAY_DEFAULT 8'd44

`endif

// ==== hdl/md_core_pkg.sv ====
/*
 * Types shared by the core top level blocks.
 * rom_write_t carries one 16-bit ROM word, address in bytes.
 * md_pad_t follows the console pad bit order, Z at the top.
 */
`default_nettype none

`include "md_core_consts.svh"

package md_core_pkg;

	typedef struct packed {
		logic wr;
		logic [`MD_ROM_ADDR_W-1:0] addr;
		logic [`MD_ROM_DATA_W-1:0] data;
	} rom_write_t; // 42 bits

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef struct packed {
		logic sram;
		logic sram00;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} cart_quirks_t;

	typedef struct packed {
		logic gun_type; // 0 menacer style, 1 justifier style
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	typedef logic [`MD_HOST_KEY_W-1:0] host_pad_t;

	typedef struct packed {
		logic z, y, x, mode, start, b, c, a;
		logic up, down, left, right;
	} md_pad_t;

	typedef struct packed {
		logic [`MD_COLOR_W-1:0] r, g, b;
		logic hs, vs;
		logic hblank, vblank;
		logic [1:0] resolution;
		logic interlace;
	} video_in_t; // 19 bits

	typedef struct packed {
		logic [23:0] rgb;
		logic de, hs, vs;
	} video_out_t;

endpackage

`default_nettype wire

// ==== hdl/input_sync.sv ====
/*
 * Three flop synchronizer into clk_sys, no reset.
 * Bits of a wide payload are not resampled together, so a
 * multi-bit value may show a mixed word for one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module input_sync #(
	parameter type payload_t = logic
) (
	input wire logic clk_sys,
	input wire payload_t d,
	output payload_t q
);

	payload_t meta_q; // first stage may go metastable
	payload_t stab_q;

	always_ff @(posedge clk_sys) begin
		meta_q <= d;
		stab_q <= meta_q;
		q <= stab_q;
	end

endmodule

`default_nettype wire

// ==== hdl/cart_load_monitor.sv ====
/*
 * Watches the ROM download and decodes the header region bytes.
 * Writes count only while download is high. The console is held in
 * reset from the region update until header-ready drops again.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_consts.svh"

module cart_load_monitor (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic download,
	input wire md_core_pkg::rom_write_t rom_wr,
	input wire logic host_run,
	output logic [`MD_ROM_ADDR_W-1:0] rom_size,
	output md_core_pkg::region_t region,
	output logic export_region,
	output logic system_reset
);
	import md_core_pkg::*;

	logic download_q;
	logic dl_rise, dl_fall;
	logic wr_ok;
	logic [`MD_ROM_ADDR_W-1:0] last_addr;
	logic [2:0] hdr_flags, flags_nxt; // {e, u, j}
	logic [2:0] lo_hit;
	logic [3:0] hrgn;
	logic hdr_ready, hdr_ready_q;
	logic region_hold;

	// letter byte to a one-hot {e, u, j}
	function automatic logic [2:0] letter_hit(input logic [7:0] c);
		case (c)
			"J": return 3'b001;
			"U": return 3'b010;
			"E": return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	assign dl_rise = download & ~download_q;
	assign dl_fall = ~download & download_q;
	assign wr_ok = rom_wr.wr & download;
	assign hrgn = rom_wr.data[3:0] - 4'd7; // 'A'..'F' back to 10..15
	assign lo_hit = letter_hit(rom_wr.data[7:0]);

	////////////////////////////////////////
	// region letter flags

	always_comb begin
		flags_nxt = hdr_flags;
		if (dl_rise)
			flags_nxt = 3'b000;
		if (wr_ok && rom_wr.addr == `MD_HDR_REGION_A) begin
			if (|lo_hit)
				flags_nxt = flags_nxt | lo_hit;
			else if (rom_wr.data[7:0] >= "0" && rom_wr.data[7:0] <= "9")
				flags_nxt = {rom_wr.data[3], rom_wr.data[2], rom_wr.data[0]};
			else if (rom_wr.data[7:0] >= "A" && rom_wr.data[7:0] <= "F")
				flags_nxt = {hrgn[3], hrgn[2], hrgn[0]};
			flags_nxt = flags_nxt | letter_hit(rom_wr.data[15:8]); // high byte after
		end
		if (wr_ok && rom_wr.addr == `MD_HDR_REGION_B)
			flags_nxt = flags_nxt | lo_hit;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			hdr_flags <= 3'b000;
			hdr_ready <= 1'b0;
			last_addr <= '0;
			rom_size <= '0;
		end else begin
			download_q <= download;
			hdr_flags <= flags_nxt;
			if (dl_fall) begin
				rom_size <= last_addr;
				hdr_ready <= 1'b0;
			end
			if (wr_ok) begin
				last_addr <= rom_wr.addr;
				if (rom_wr.addr == `MD_HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// region apply and reset window

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hdr_ready_q <= 1'b0;
			region_hold <= 1'b0;
			region <= US;
		end else begin
			hdr_ready_q <= hdr_ready;
			if (hdr_ready && !hdr_ready_q) begin
				region_hold <= 1'b1;
				if (hdr_flags[1]) region <= US; // US wins over EU and JP
				else if (hdr_flags[2]) region <= EU;
				else if (hdr_flags[0]) region <= JP;
				else region <= US;
			end
			if (!hdr_ready && hdr_ready_q)
				region_hold <= 1'b0;
		end
	end

	assign export_region = (region != JP);
	assign system_reset = region_hold | ~host_run;

endmodule

`default_nettype wire

// ==== hdl/cart_compat_table.sv ====
/*
 * Product ID capture and per-title compatibility settings.
 * The ID is only complete once all five ID words are written
 * before the commit word. Flags clear while a download runs.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_consts.svh"

module cart_compat_table (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic download,
	input wire md_core_pkg::rom_write_t rom_wr,
	output md_core_pkg::cart_quirks_t quirks,
	output md_core_pkg::gun_cfg_t gun
);
	import md_core_pkg::*;

	logic wr_ok;
	logic [63:0] cart_id; // 8 ASCII chars, first char on top
	cart_quirks_t quirk_hit;
	gun_cfg_t gun_hit;

	assign wr_ok = rom_wr.wr & download;

	// header words arrive big endian, so swap bytes
	always_ff @(posedge clk_sys) begin
		if (wr_ok) begin
			case (rom_wr.addr)
				`MD_HDR_ID_FIRST: cart_id[63:56] <= rom_wr.data[15:8];
				`MD_HDR_ID_FIRST + 2: cart_id[55:40] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`MD_HDR_ID_FIRST + 4: cart_id[39:24] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`MD_HDR_ID_FIRST + 6: cart_id[23:8] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`MD_HDR_ID_LAST: cart_id[7:0] <= rom_wr.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// title table

	always_comb begin
		quirk_hit = '0;
		case (cart_id)
			"T-081276", "T-81406 ", "T-081586",
			"T-81576 ", "T-81476 ": quirk_hit.sram = 1'b1; // serial sram titles
			"MK-1215 ", "G-4060  ", "00001211",
			"MK-1228 ", "G-5538  ", "00004076",
			"T-12046 ", "T-12053 ", "G-4524  ": quirk_hit.eeprom = 1'b1;
			"T-113016": quirk_hit.noram = 1'b1; // fake ram check in Puggsy
			"T-89016 ": quirk_hit.fifo = 1'b1;
			"T-574023", "T-574013": quirk_hit.pier = 1'b1;
			"MK-1229 ", "G-7001  ": quirk_hit.svp = 1'b1; // Virtua Racing
			"T-35036 ", "T-25073 ", "MK-1137-": quirk_hit.fmbusy = 1'b1; // Hellfire
			"T-68???-": quirk_hit.schan = 1'b1;
			" GM 0000": quirk_hit.sram00 = 1'b1;
			default: ;
		endcase
	end

	// lightgun type and sensor timing
	always_comb begin
		gun_hit = '{gun_type: 1'b0, sensor_delay: `MD_GUN_DELAY_DEFAULT};
		case (cart_id)
			"MK-1533 ": gun_hit = '{gun_type: 1'b0, sensor_delay: 8'd100}; // Body Count
			"T-95096-": gun_hit = '{gun_type: 1'b1, sensor_delay: 8'd52};
			"T-95136-": gun_hit = '{gun_type: 1'b1, sensor_delay: 8'd30};
			"MK-1658 ": gun_hit = '{gun_type: 1'b0, sensor_delay: 8'd120}; // 6-in-1
			"T-081156": gun_hit = '{gun_type: 1'b0, sensor_delay: 8'd126};
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			quirks <= '0;
			gun <= '{gun_type: 1'b0, sensor_delay: `MD_GUN_DELAY_DEFAULT};
		end else begin
			if (download)
				quirks <= '0;
			// commit always lands inside a download, so it wins the clear
			if (wr_ok && rom_wr.addr == `MD_HDR_ID_COMMIT) begin
				quirks <= quirk_hit;
				gun <= gun_hit;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pad_input_map.sv ====
/*
 * Brings four host pads and the menu flag into clk_sys and maps
 * host keys onto the console pad word. Latency is three cycles.
 * Bits are active high on both sides.
 */
`timescale 1ns/1ps
`default_nettype none

module pad_input_map (
	input wire logic clk_sys,
	input wire md_core_pkg::host_pad_t host_pad [4],
	input wire logic in_menu,
	output md_core_pkg::md_pad_t md_pad [4],
	output logic pause
);
	import md_core_pkg::*;

	for (genvar i = 0; i < 4; i++) begin : g_pad
		host_pad_t key_s;

		input_sync #(.payload_t(host_pad_t)) u_key_sync (
			.clk_sys(clk_sys),
			.d(host_pad[i]),
			.q(key_s)
		);

		// r1 z, x y, l1 x, select mode
		assign md_pad[i] = '{
			z: key_s[9], y: key_s[6], x: key_s[8],
			mode: key_s[14], start: key_s[15],
			b: key_s[4], c: key_s[5], a: key_s[7],
			up: key_s[0], down: key_s[1], left: key_s[2], right: key_s[3]
		};
	end

	input_sync #(.payload_t(logic)) u_pause_sync (
		.clk_sys(clk_sys),
		.d(in_menu),
		.q(pause)
	); // console pauses while the host menu is open

endmodule

`default_nettype wire

// ==== hdl/video_out_encoder.sv ====
/*
 * Pixel output stage, advances only on ce_pix.
 * rgb carries the video mode code during blanking for the scaler.
 * Sync outputs are one-sample pulses on the rising sync edge.
 */
`timescale 1ns/1ps
`default_nettype none

module video_out_encoder (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic ce_pix,
	input wire md_core_pkg::video_in_t vid_in,
	output md_core_pkg::video_out_t vid_out
);
	import md_core_pkg::*;

	// 4 bit console level to 8 bit
	localparam logic [7:0] COLOR_LUT [16] = '{
		8'd0, 8'd27, 8'd49, 8'd71,
		8'd87, 8'd103, 8'd119, 8'd130,
		8'd146, 8'd157, 8'd174, 8'd190,
		8'd206, 8'd228, 8'd255, 8'd255
	};

	logic active;
	logic [10:0] mode_code;
	logic [23:0] rgb_nxt;
	logic [23:0] rgb_q;
	logic de_q, hs_q, vs_q;
	logic hs_prev, vs_prev;

	assign active = ~(vid_in.hblank | vid_in.vblank);

	always_comb begin
		case (vid_in.resolution)
			2'd0: mode_code = 11'd0; // 256x224
			2'd1: mode_code = vid_in.interlace ? 11'd4 : 11'd1; // 320x448i or 320x224
			2'd2: mode_code = 11'd2;
			default: mode_code = 11'd3;
		endcase
		if (active)
			rgb_nxt = {COLOR_LUT[vid_in.r], COLOR_LUT[vid_in.g], COLOR_LUT[vid_in.b]};
		else
			rgb_nxt = {mode_code, 13'd0};
	end

	////////////////////////////////////////
	// output registers

	always_ff @(posedge clk_sys) begin
		if (ce_pix)
			rgb_q <= rgb_nxt;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			de_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
		end else if (ce_pix) begin
			de_q <= active;
			hs_q <= vid_in.hs & ~hs_prev; // rising edge only
			vs_q <= vid_in.vs & ~vs_prev;
			hs_prev <= vid_in.hs;
			vs_prev <= vid_in.vs;
		end
	end

	assign vid_out = video_out_t'{rgb: rgb_q, de: de_q, hs: hs_q, vs: vs_q};

endmodule

`default_nettype wire

// ==== hdl/md_core_top.sv ====
/*
 * Core top level: header path and pixel path side by side on clk_sys.
 * ROM writes are plain strobes and are never stalled.
 * The console system itself is not part of this level.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_consts.svh"

module md_core_top (
	input wire logic clk_sys,
	input wire logic rst_n,
	input wire logic download,
	input wire logic host_run,
	input wire logic ce_pix,
	input wire logic in_menu,
	input wire md_core_pkg::rom_write_t rom_wr,
	input wire md_core_pkg::host_pad_t host_pad [4],
	input wire md_core_pkg::video_in_t vid_in,
	output logic [`MD_ROM_ADDR_W-1:0] rom_size,
	output md_core_pkg::region_t region,
	output logic export_region,
	output logic system_reset,
	output md_core_pkg::cart_quirks_t quirks,
	output md_core_pkg::gun_cfg_t gun,
	output md_core_pkg::md_pad_t md_pad [4],
	output logic pause,
	output md_core_pkg::video_out_t vid_out
);

	////////////////////////////////////////
	// header path

	cart_load_monitor u_load_monitor (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.download(download),
		.rom_wr(rom_wr),
		.host_run(host_run),
		.rom_size(rom_size),
		.region(region),
		.export_region(export_region),
		.system_reset(system_reset)
	);

	cart_compat_table u_compat_table (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.download(download),
		.rom_wr(rom_wr),
		.quirks(quirks),
		.gun(gun)
	);

	////////////////////////////////////////
	// pads and pixels

	pad_input_map u_pad_map (
		.clk_sys(clk_sys),
		.host_pad(host_pad),
		.in_menu(in_menu),
		.md_pad(md_pad),
		.pause(pause)
	);

	video_out_encoder u_video_out (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.ce_pix(ce_pix),
		.vid_in(vid_in),
		.vid_out(vid_out)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_md_core.sv ====
/*
 * Testbench for md_core_top, records come from testbench/md_core_tests.txt.
 * Run from the project root so the relative file path resolves.
 * Inputs change 1 ns after the rising edge, outputs are read there too.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_core_consts.svh"

module tb_md_core;
	import md_core_pkg::*;

	localparam int CYCLES_PER_RECORD = 40;
	localparam int KEY_SRC [12] = '{9, 6, 8, 14, 15, 4, 5, 7, 0, 1, 2, 3}; // Z down to right
	localparam logic [7:0] COLOR_LEVELS [16] = '{
		8'd0, 8'd27, 8'd49, 8'd71, 8'd87, 8'd103, 8'd119, 8'd130,
		8'd146, 8'd157, 8'd174, 8'd190, 8'd206, 8'd228, 8'd255, 8'd255
	};

	logic clk_sys, rst_n, download, host_run, ce_pix, in_menu;
	rom_write_t rom_wr;
	host_pad_t host_pad [4];
	video_in_t vid_in;
	logic [`MD_ROM_ADDR_W-1:0] rom_size;
	region_t region;
	logic export_region, system_reset, pause;
	cart_quirks_t quirks;
	gun_cfg_t gun;
	md_pad_t md_pad [4];
	video_out_t vid_out;

	string tests [$];
	int errors, tests_failed, cycle_count, cycle_limit;
	logic [31:0] lcg_state;
	video_out_t exp_vid; // reference video state
	logic rgb_known, prev_hs, prev_vs;
	logic [64:0] pad_hist [$]; // {in_menu, pad3..pad0}

	md_core_top dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .download(download), .host_run(host_run),
		.ce_pix(ce_pix), .in_menu(in_menu), .rom_wr(rom_wr), .host_pad(host_pad),
		.vid_in(vid_in), .rom_size(rom_size), .region(region),
		.export_region(export_region), .system_reset(system_reset), .quirks(quirks),
		.gun(gun), .md_pad(md_pad), .pause(pause), .vid_out(vid_out)
	);

	always #5 clk_sys = ~clk_sys;
	always @(posedge clk_sys) cycle_count <= cycle_count + 1;

	////////////////////////////////////////
	// helpers

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [11:0] remap_keys(input logic [15:0] keys);
		logic [11:0] pad;
		for (int i = 0; i < 12; i++)
			pad[11 - i] = keys[KEY_SRC[i]];
		return pad;
	endfunction

	// ID chars sit at bytes 183h..18Ah with spaces around them
	function automatic logic [7:0] id_byte(input logic [63:0] id, input int addr);
		int k;
		k = addr - 'h183;
		if (k < 0 || k > 7)
			return 8'h20;
		return id[63 - 8 * k -: 8];
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic rom_write(input logic [`MD_ROM_ADDR_W-1:0] addr, input logic [15:0] data);
		rom_wr = '{wr: 1'b1, addr: addr, data: data};
		step();
		rom_wr.wr = 1'b0;
	endtask

	////////////////////////////////////////
	// test kinds

	task automatic region_test(input logic [15:0] w_a, input logic [15:0] w_b,
			input logic [`MD_ROM_ADDR_W-1:0] last_addr, input logic [1:0] exp_region,
			input logic exp_export);
		download = 1'b1;
		step();
		rom_write(`MD_HDR_REGION_A, w_a);
		rom_write(`MD_HDR_REGION_B, w_b);
		rom_write(`MD_HDR_END, 16'h0000);
		check_value("system_reset", system_reset, 0); // hold not yet up
		rom_write(last_addr, 16'h0000);
		check_value("system_reset", system_reset, 1);
		check_value("region", region, exp_region);
		check_value("export_region", export_region, exp_export);
		download = 1'b0;
		step();
		check_value("rom_size", rom_size, last_addr);
		check_value("system_reset", system_reset, 1);
		step();
		check_value("system_reset", system_reset, 0);
	endtask

	task automatic host_run_test();
		host_run = 1'b0;
		step();
		check_value("system_reset", system_reset, 1);
		host_run = 1'b1;
		step();
		check_value("system_reset", system_reset, 0);
	endtask

	task automatic compat_test(input logic [63:0] id, input logic [8:0] exp_quirks,
			input logic exp_type, input logic [7:0] exp_delay);
		logic [`MD_ROM_ADDR_W-1:0] a;
		download = 1'b1;
		step();
		check_value("quirks", quirks, 0); // cleared by the new download
		for (int i = 0; i < 5; i++) begin
			a = `MD_HDR_ID_FIRST + 25'(2 * i);
			rom_write(a, {id_byte(id, a + 1), id_byte(id, a)});
		end
		rom_write(`MD_HDR_ID_COMMIT, 16'h0000);
		check_value("quirks", quirks, exp_quirks);
		check_value("gun.gun_type", gun.gun_type, exp_type);
		check_value("gun.sensor_delay", gun.sensor_delay, exp_delay);
		download = 1'b0;
		step();
		check_value("quirks", quirks, exp_quirks); // kept once download ends
	endtask

	task automatic pad_test(input int cycles);
		logic [64:0] due;
		logic [31:0] r;
		pad_hist.delete();
		for (int n = 0; n < cycles; n++) begin
			for (int p = 0; p < 4; p++) begin
				r = rand_word();
				host_pad[p] = r[31:16];
			end
			r = rand_word();
			in_menu = r[31];
			pad_hist.push_back({in_menu, host_pad[3], host_pad[2], host_pad[1], host_pad[0]});
			step();
			if (pad_hist.size() == 3) begin // third edge after the drive
				due = pad_hist.pop_front();
				for (int p = 0; p < 4; p++)
					check_value($sformatf("md_pad[%0d]", p), md_pad[p],
						remap_keys(due[16 * p +: 16]));
				check_value("pause", pause, due[64]);
			end
		end
	endtask

	task automatic video_sample(input logic [10:0] blank_code);
		logic active;
		active = ~(vid_in.hblank | vid_in.vblank);
		if (ce_pix) begin
			exp_vid.de = active;
			exp_vid.rgb = active ? {COLOR_LEVELS[vid_in.r], COLOR_LEVELS[vid_in.g],
				COLOR_LEVELS[vid_in.b]} : {blank_code, 13'd0};
			exp_vid.hs = vid_in.hs & ~prev_hs; // pulse on the rise
			exp_vid.vs = vid_in.vs & ~prev_vs;
			prev_hs = vid_in.hs;
			prev_vs = vid_in.vs;
			rgb_known = 1'b1;
		end
		step();
		check_value("vid_out.de", vid_out.de, exp_vid.de);
		check_value("vid_out.hs", vid_out.hs, exp_vid.hs);
		check_value("vid_out.vs", vid_out.vs, exp_vid.vs);
		if (rgb_known)
			check_value("vid_out.rgb", vid_out.rgb, exp_vid.rgb);
	endtask

	task automatic video_test(input int cycles);
		logic [31:0] r;
		for (int n = 0; n < cycles; n++) begin
			r = rand_word();
			vid_in = '{r: r[31:28], g: r[27:24], b: r[23:20], hs: r[19], vs: r[18],
				hblank: 1'b0, vblank: 1'b0, resolution: r[17:16], interlace: r[15]};
			ce_pix = r[14];
			video_sample(11'd0);
		end
		ce_pix = 1'b0;
	endtask

	task automatic blank_test(input logic [1:0] res, input logic il, input logic hb,
			input logic vb, input logic [10:0] code);
		vid_in = '{r: 4'd5, g: 4'd9, b: 4'd12, hs: 1'b0, vs: 1'b0,
			hblank: hb, vblank: vb, resolution: res, interlace: il};
		ce_pix = 1'b1;
		video_sample(code);
		ce_pix = 1'b0;
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin : run_tests
		int fd;
		int failed_before;
		string rec;
		logic [7:0] kind;
		logic [63:0] o1, o2, o3, o4, o5;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		download = 1'b0;
		host_run = 1'b1;
		ce_pix = 1'b0;
		in_menu = 1'b0;
		rom_wr = '0;
		vid_in = '0;
		for (int p = 0; p < 4; p++)
			host_pad[p] = '0;
		errors = 0;
		tests_failed = 0;
		cycle_limit = 0;
		lcg_state = 32'h44e83c94;
		exp_vid = '0;
		rgb_known = 1'b0;
		prev_hs = 1'b0;
		prev_vs = 1'b0;

		fd = $fopen("testbench/md_core_tests.txt", "r");
		if (fd == 0) begin
			$display("test file testbench/md_core_tests.txt could not be opened");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				rec = "";
				if ($fgets(rec, fd) != 0 && rec.len() > 1 && rec[0] != "#")
					tests.push_back(rec);
			end
			$fclose(fd);
			if (tests.size() == 0) begin
				$display("test file holds no records");
				errors++;
			end
		end
		cycle_limit = tests.size() * CYCLES_PER_RECORD;

		repeat (5) step(); // reset held low
		rst_n = 1'b1;
		step();

		foreach (tests[t]) begin
			failed_before = errors;
			rec = tests[t];
			kind = rec[0];
			o1 = '0;
			o2 = '0;
			o3 = '0;
			o4 = '0;
			o5 = '0;
			void'($sscanf(rec.substr(1, rec.len() - 1), "%h %h %h %h %h", o1, o2, o3, o4, o5));
			case (kind)
				"L": region_test(o1[15:0], o2[15:0], o3[24:0], o4[1:0], o5[0]);
				"R": host_run_test();
				"C": compat_test(o1, o2[8:0], o3[0], o4[7:0]);
				"P": pad_test(int'(o1));
				"V": video_test(int'(o1));
				"B": blank_test(o1[1:0], o2[0], o3[0], o4[0], o5[10:0]);
				default: begin
					$display("record %0d has an unknown kind letter %c", t + 1, kind);
					errors++;
				end
			endcase
			if (errors != failed_before)
				tests_failed++;
			$display("test %0d (%c): %s", t + 1, kind, errors == failed_before ? "pass" : "fail");
		end

		$display("%0d tests run, %0d failed, %0d errors", tests.size(), tests_failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// ends a run that stops making progress
	initial begin : watchdog
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit + 10)
			@(posedge clk_sys);
		$display("run did not finish within %0d cycles", cycle_limit);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/md_core_tests.txt ====
# all fields hex | L w1f0 w1f2 last_addr region export | C id quirks gun_type delay | R
# P cycles | V cycles | B resolution interlace hblank vblank mode_code
L 204a 2020 7ffe 0 0
L 554a 2020 3ffffe 1 1
L 2045 2020 1fffffe 2 1
L 2031 2020 ffffe 0 0
L 2020 2045 80000 2 1
L 2034 2020 20000 1 1
L 2038 2020 100000 2 1
L 2043 2020 40000 1 1
L 4a41 2020 200000 2 1
L 4a20 2020 3fe 0 0
L 2020 2020 202 1 1
L 2020 204a 1000 0 0
L 2020 2055 7fffe 1 1
L 2046 2020 fffffe 1 1
R
C 542D303831323736 100 0 2c
C 4D4B2D3132313520 040 0 2c
C 542D313133303136 010 0 2c
C 542D383930313620 020 0 2c
C 542D353734303233 008 0 2c
C 4D4B2D3132323920 004 0 2c
C 542D333530333620 002 0 2c
C 542D36383F3F3F2D 001 0 2c
C 20474D2030303030 080 0 2c
C 542D393939393920 000 0 2c
C 4D4B2D3135333320 000 0 64
C 542D39353039362D 000 1 34
C 542D39353133362D 000 1 1e
C 4D4B2D3136353820 000 0 78
C 542D303831313536 000 0 7e
C 542D393939393920 000 0 2c
P 14
P 20
V 1e
B 0 0 1 0 000
B 1 0 1 0 001
B 1 1 0 1 004
B 2 0 1 1 002
B 3 1 0 1 003
V 20

// ==== project.f ====
+incdir+include
hdl/md_core_pkg.sv
hdl/input_sync.sv
hdl/cart_load_monitor.sv
hdl/cart_compat_table.sv
hdl/pad_input_map.sv
hdl/video_out_encoder.sv
hdl/md_core_top.sv
testbench/tb_md_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_md_core
FILELIST  := project.f
VFLAGS    := --binary --timing -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
